//--- include/qla_defines.svh
// QLA motor controller core constants
// bus widths, address fields, register offsets and timing
`ifndef QLA_DEFINES_SVH
`define QLA_DEFINES_SVH

// --------------------
// sizes
`define QLA_NUM_AXES         4
`define QLA_ADDR_W           16
`define QLA_DATA_W           32
`define QLA_CMD_W            16      // dac and adc word

// --------------------
// address map
// addr[15:12] space, addr[7:4] channel (0 = global), addr[3:0] offset
`define QLA_ADDR_MAIN        4'h0
`define QLA_OFF_STATUS       4'h0    // channel 0 only
`define QLA_OFF_ADC_DATA     4'h0    // channels 1-4
`define QLA_OFF_DAC_CTRL     4'h1
`define QLA_OFF_MOTOR_STATUS 4'h2

// --------------------
// dac serial link
`define QLA_DAC_SCLK_DIV     2       // sysclk cycles per sclk half period
`define QLA_DAC_FRAME_BITS   24      // opcode, channel, command

// --------------------
// safety monitor
`define QLA_SAFETY_SAMPLES   4       // consecutive over-limit samples
`define QLA_SAFETY_MARGIN    16'h0100
`define QLA_CUR_MID          16'h8000 // offset binary zero current

`endif

//--- src/qla_pkg.sv
// QLA motor controller shared types
// register bus, adc feedback bundle, dac pins and serializer encodings
`default_nettype none

`include "qla_defines.svh"

package qla_pkg;

    // host write bus, one cycle per quadlet
    typedef struct packed {
        logic [`QLA_ADDR_W-1:0] waddr;
        logic [`QLA_DATA_W-1:0] wdata;
        logic                   wen;     // write strobe
        logic                   blk_wen; // held through a block write
    } reg_wr_t;

    // converted adc words, index 0 is axis 1
    typedef struct packed {
        logic [`QLA_NUM_AXES-1:0][`QLA_CMD_W-1:0] cur_fb;
        logic [`QLA_NUM_AXES-1:0][`QLA_CMD_W-1:0] pot_fb;
        logic                                     cur_valid; // new current sample
    } adc_fb_t;

    // quad dac pins
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic csel;   // active low
    } dac_spi_t;

    // --------------------
    // serializer states
    typedef enum logic [1:0] {
        DAC_IDLE  = 2'd0,
        DAC_LOAD  = 2'd1,   // build frame for current axis
        DAC_SHIFT = 2'd2,   // csel low, clocking bits
        DAC_GAP   = 2'd3    // csel high between frames
    } dac_state_e;

    // dac command nibble
    typedef enum logic [3:0] {
        DAC_WRITE_UPDATE = 4'h3,
        DAC_NOP          = 4'hf
    } dac_opcode_e;

endpackage

`default_nettype wire

//--- src/motor_cmd_regs.sv
// commanded current registers, one per axis
// a block write of DAC_CTRL requests a dac update once the block ends
`timescale 1ns/10ps
`default_nettype none

`include "qla_defines.svh"

module motor_cmd_regs (
    input  logic                                     sysclk,
    input  logic                                     rst_n,
    input  qla_pkg::reg_wr_t                         reg_wr,
    input  logic                                     dac_busy,
    output logic [`QLA_NUM_AXES-1:0][`QLA_CMD_W-1:0] cur_cmd,
    output logic                                     dac_start
);

    logic [3:0] wr_chan;     // channel field of write address
    logic [3:0] wr_idx;      // zero based axis
    logic       chan_ok;     // axis 1..4, channel 0 is global space
    logic       dac_wr;      // write hits a DAC_CTRL register
    logic       upd_req;     // update pending

    // --------------------
    // address decode
    assign wr_chan = reg_wr.waddr[7:4];
    assign wr_idx  = wr_chan - 4'd1;
    assign chan_ok = (wr_chan != 4'd0) && (wr_chan <= 4'(`QLA_NUM_AXES));
    assign dac_wr  = reg_wr.wen && chan_ok
                  && (reg_wr.waddr[15:12] == `QLA_ADDR_MAIN)
                  && (reg_wr.waddr[3:0] == `QLA_OFF_DAC_CTRL);

    // command storage, midscale is zero current
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd <= {`QLA_NUM_AXES{`QLA_CUR_MID}};
        end else if (dac_wr) begin
            cur_cmd[wr_idx[1:0]] <= reg_wr.wdata[`QLA_CMD_W-1:0];  // low half only
        end
    end

    // --------------------
    // update request
    // set by any block DAC_CTRL write, one pending request covers all
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            upd_req <= 1'b0;
        end else if (dac_wr && reg_wr.blk_wen) begin
            upd_req <= 1'b1;
        end else if (dac_start) begin
            upd_req <= 1'b0;                  // handed to the serializer
        end
    end

    // fire once the block is over and the dac is free
    assign dac_start = upd_req && !dac_busy && !reg_wr.blk_wen;

endmodule

`default_nettype wire

//--- src/dac_spi_ctrl.sv
// quad dac serializer
// sends one 24 bit write-and-update frame per axis, axis 1 first,
// msb first with mosi changing on the falling sclk edge
`timescale 1ns/10ps
`default_nettype none

`include "qla_defines.svh"

module dac_spi_ctrl (
    input  logic                                     sysclk,
    input  logic                                     rst_n,
    input  logic                                     dac_start,
    input  logic [`QLA_NUM_AXES-1:0][`QLA_CMD_W-1:0] cur_cmd,
    output qla_pkg::dac_spi_t                        dac_spi,
    output logic                                     dac_busy
);

    localparam int DIV    = `QLA_DAC_SCLK_DIV;
    localparam int FBITS  = `QLA_DAC_FRAME_BITS;
    localparam int DIV_W  = $clog2(2 * DIV);
    localparam int BIT_W  = $clog2(FBITS);
    localparam int AXIS_W = $clog2(`QLA_NUM_AXES);

    qla_pkg::dac_state_e state;
    logic [DIV_W-1:0]  div_cnt;    // sysclk cycles within half period
    logic [BIT_W-1:0]  bit_cnt;    // bits sent in this frame
    logic [AXIS_W-1:0] axis_cnt;
    logic              sclk;
    logic              csel;
    logic              half_done;  // end of sclk half period
    logic              gap_done;   // csel high long enough
    logic [FBITS-1:0]  sreg;       // frame shift register
    logic [`QLA_NUM_AXES-1:0][`QLA_CMD_W-1:0] cmd_snap;

    assign half_done = (div_cnt == DIV_W'(DIV - 1));
    assign gap_done  = (div_cnt == DIV_W'(2 * DIV - 2));  // plus the LOAD cycle

    assign dac_spi = '{sclk: sclk, mosi: sreg[FBITS-1], csel: csel};

    // --------------------
    // control FSM
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state    <= qla_pkg::DAC_IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            axis_cnt <= '0;
            sclk     <= 1'b0;
            csel     <= 1'b1;
            dac_busy <= 1'b0;
        end else begin
            case (state)
                qla_pkg::DAC_IDLE: if (dac_start) begin
                    dac_busy <= 1'b1;
                    axis_cnt <= '0;
                    state    <= qla_pkg::DAC_LOAD;
                end
                qla_pkg::DAC_LOAD: begin
                    csel    <= 1'b0;        // frame starts, first bit already on mosi
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= qla_pkg::DAC_SHIFT;
                end
                qla_pkg::DAC_SHIFT: if (half_done) begin
                    div_cnt <= '0;
                    sclk    <= ~sclk;
                    if (sclk && bit_cnt == BIT_W'(FBITS - 1)) begin
                        csel  <= 1'b1;      // last falling edge closes the frame
                        state <= qla_pkg::DAC_GAP;
                    end else if (sclk) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
                qla_pkg::DAC_GAP: if (gap_done) begin
                    div_cnt <= '0;
                    if (axis_cnt == AXIS_W'(`QLA_NUM_AXES - 1)) begin
                        dac_busy <= 1'b0;   // all four sent
                        state    <= qla_pkg::DAC_IDLE;
                    end else begin
                        axis_cnt <= axis_cnt + 1'b1;
                        state    <= qla_pkg::DAC_LOAD;
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
                default: state <= qla_pkg::DAC_IDLE;
            endcase
        end
    end

    // --------------------
    // snapshot and shift path
    always_ff @(posedge sysclk) begin
        if (state == qla_pkg::DAC_IDLE && dac_start)
            cmd_snap <= cur_cmd;    // later writes cannot tear a frame
        if (state == qla_pkg::DAC_LOAD)
            sreg <= {qla_pkg::DAC_WRITE_UPDATE, 4'(axis_cnt), cmd_snap[axis_cnt]};
        else if (state == qla_pkg::DAC_SHIFT && half_done && sclk)
            sreg <= {sreg[FBITS-2:0], 1'b1};                    // next bit on falling edge
        else if (state == qla_pkg::DAC_IDLE)
            sreg <= {qla_pkg::DAC_NOP, {(FBITS - 4){1'b1}}};    // mosi parks high
    end

endmodule

`default_nettype wire

//--- src/safety_check.sv
// per-axis overcurrent monitor
// trips when |fb| > 2*|cmd| + margin for several samples in a row,
// magnitudes taken about midscale
`timescale 1ns/10ps
`default_nettype none

`include "qla_defines.svh"

module safety_check (
    input  logic                  sysclk,
    input  logic                  rst_n,
    input  logic [`QLA_CMD_W-1:0] cur_fb,
    input  logic [`QLA_CMD_W-1:0] cur_cmd,
    input  logic                  cur_valid,
    input  logic                  amp_clear,
    output logic                  amp_trip
);

    localparam int CNT_W = $clog2(`QLA_SAFETY_SAMPLES + 1);

    logic [`QLA_CMD_W-1:0] fb_mag;
    logic [`QLA_CMD_W-1:0] cmd_mag;
    logic [`QLA_CMD_W+1:0] limit;      // 2*cmd + margin, two spare bits
    logic                  over;
    logic [CNT_W-1:0]      over_cnt;   // consecutive over-limit samples

    // distance from midscale
    assign fb_mag  = (cur_fb >= `QLA_CUR_MID)  ? cur_fb - `QLA_CUR_MID  : `QLA_CUR_MID - cur_fb;
    assign cmd_mag = (cur_cmd >= `QLA_CUR_MID) ? cur_cmd - `QLA_CUR_MID : `QLA_CUR_MID - cur_cmd;
    assign limit   = {cmd_mag, 1'b0} + `QLA_SAFETY_MARGIN;
    assign over    = {2'b00, fb_mag} > limit;

    always_ff @(posedge sysclk) begin
        if (!rst_n || amp_clear) begin
            over_cnt <= '0;
            amp_trip <= 1'b0;
        end else begin
            if (cur_valid) begin
                if (!over)
                    over_cnt <= '0;                  // run broken
                else if (over_cnt != CNT_W'(`QLA_SAFETY_SAMPLES))
                    over_cnt <= over_cnt + 1'b1;     // saturates at the limit
            end
            if (over_cnt == CNT_W'(`QLA_SAFETY_SAMPLES))
                amp_trip <= 1'b1;                    // held until cleared
        end
    end

endmodule

`default_nettype wire

//--- src/board_regs.sv
// board status register and read path
// power and amplifier enables with masked writes, trip clearing,
// and the registered read data mux for all board registers
`timescale 1ns/10ps
`default_nettype none

`include "qla_defines.svh"

module board_regs (
    input  logic                                     sysclk,
    input  logic                                     rst_n,
    input  qla_pkg::reg_wr_t                         reg_wr,
    input  logic [`QLA_ADDR_W-1:0]                   reg_raddr,
    output logic [`QLA_DATA_W-1:0]                   reg_rdata,
    input  logic [`QLA_NUM_AXES-1:0][`QLA_CMD_W-1:0] cur_cmd,
    input  qla_pkg::adc_fb_t                         adc,
    input  logic [3:0]                               amp_trip,
    input  logic [3:0]                               board_id,
    output logic [3:0]                               amp_clear,
    output logic [3:0]                               amp_en
);

    logic                  status_wr;
    logic                  pwr_en;       // bit 19
    logic [3:0]            amp_en_cmd;   // bits 3:0
    logic                  pwr_set;      // masked write of power to 1
    logic [3:0]            rd_idx;
    logic                  rd_axis;      // read hits channel 1-4
    logic [`QLA_DATA_W-1:0] rd_next;

    // --------------------
    // status write
    assign status_wr = reg_wr.wen && (reg_wr.waddr[15:12] == `QLA_ADDR_MAIN)
                    && (reg_wr.waddr[7:4] == 4'd0)
                    && (reg_wr.waddr[3:0] == `QLA_OFF_STATUS);
    assign pwr_set   = status_wr && reg_wr.wdata[18] && reg_wr.wdata[19];

    // re-enabling an axis or power releases the safety latch
    assign amp_clear = {4{pwr_set}}
                     | ({4{status_wr}} & reg_wr.wdata[11:8] & reg_wr.wdata[3:0]);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            pwr_en     <= 1'b0;
            amp_en_cmd <= 4'd0;
            amp_en     <= 4'd0;
        end else begin
            if (status_wr && reg_wr.wdata[18])
                pwr_en <= reg_wr.wdata[19];
            if (status_wr)   // per-bit mask in 11:8
                amp_en_cmd <= (amp_en_cmd & ~reg_wr.wdata[11:8])
                            | (reg_wr.wdata[3:0] & reg_wr.wdata[11:8]);
            amp_en <= {4{pwr_en}} & amp_en_cmd & ~amp_trip;   // one cycle behind
        end
    end

    // --------------------
    // read mux
    assign rd_idx  = reg_raddr[7:4] - 4'd1;
    assign rd_axis = (reg_raddr[7:4] != 4'd0) && (reg_raddr[7:4] <= 4'(`QLA_NUM_AXES));

    always_comb begin
        rd_next = '0;
        if (reg_raddr[15:12] == `QLA_ADDR_MAIN) begin
            if (reg_raddr[7:4] == 4'd0 && reg_raddr[3:0] == `QLA_OFF_STATUS) begin
                rd_next[27:24] = board_id;
                rd_next[19]    = pwr_en;
                rd_next[7:4]   = amp_trip;
                rd_next[3:0]   = amp_en;
            end else if (rd_axis) begin
                case (reg_raddr[3:0])
                    `QLA_OFF_ADC_DATA:     rd_next = {adc.pot_fb[rd_idx[1:0]],
                                                      adc.cur_fb[rd_idx[1:0]]};
                    `QLA_OFF_DAC_CTRL:     rd_next = {16'd0, cur_cmd[rd_idx[1:0]]};
                    `QLA_OFF_MOTOR_STATUS: rd_next = {3'd0, amp_en[rd_idx[1:0]], 12'd0,
                                                      cur_cmd[rd_idx[1:0]]};
                    default:               rd_next = '0;
                endcase
            end
        end
    end

    always_ff @(posedge sysclk) begin
        reg_rdata <= rd_next;   // data one clock after address
    end

endmodule

`default_nettype wire

//--- src/qla_ctrl_top.sv
// QLA motor controller core, top level
// ties the register bus to the command file, dac link,
// per-axis safety monitors and board registers
`timescale 1ns/10ps
`default_nettype none

`include "qla_defines.svh"

module qla_ctrl_top (
    input  logic                   sysclk,
    input  logic                   rst_n,
    input  qla_pkg::reg_wr_t       reg_wr,      // host write bus
    input  logic [`QLA_ADDR_W-1:0] reg_raddr,
    output logic [`QLA_DATA_W-1:0] reg_rdata,   // one clock after reg_raddr
    input  qla_pkg::adc_fb_t       adc,
    output qla_pkg::dac_spi_t      dac_spi,
    output logic [3:0]             amp_en,
    input  logic [3:0]             board_id
);

    // --------------------
    // internal wires
    logic [`QLA_NUM_AXES-1:0][`QLA_CMD_W-1:0] cur_cmd;   // commanded currents
    logic                     dac_start;   // one cycle update request
    logic                     dac_busy;
    logic [`QLA_NUM_AXES-1:0] amp_trip;    // latched overcurrent
    logic [`QLA_NUM_AXES-1:0] amp_clear;   // release from status write

    // commanded current register file
    motor_cmd_regs cmd_regs (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .dac_busy  (dac_busy),
        .cur_cmd   (cur_cmd),
        .dac_start (dac_start)
    );

    // quad dac serializer
    dac_spi_ctrl dac (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .dac_start (dac_start),
        .cur_cmd   (cur_cmd),
        .dac_spi   (dac_spi),
        .dac_busy  (dac_busy)
    );

    // --------------------
    // overcurrent monitors, one per axis
    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_safe
        safety_check safe (
            .sysclk    (sysclk),
            .rst_n     (rst_n),
            .cur_fb    (adc.cur_fb[i]),
            .cur_cmd   (cur_cmd[i]),
            .cur_valid (adc.cur_valid),
            .amp_clear (amp_clear[i]),
            .amp_trip  (amp_trip[i])
        );
    end

    // status, enables and read mux
    board_regs chan0 (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata),
        .cur_cmd   (cur_cmd),
        .adc       (adc),
        .amp_trip  (amp_trip),
        .board_id  (board_id),
        .amp_clear (amp_clear),
        .amp_en    (amp_en)
    );

endmodule

`default_nettype wire

//--- tb/tb_qla_ctrl_top.sv
// testbench for the QLA motor controller core
// runs the vectors of tb/qla_ctrl_tests.txt over the register bus
// and captures the quad DAC frames from the serial pins
`timescale 1ns/10ps
`default_nettype none

`include "qla_defines.svh"

module tb_qla_ctrl_top;

    logic                   sysclk = 1'b0;
    logic                   rst_n;
    qla_pkg::reg_wr_t       reg_wr;
    logic [`QLA_ADDR_W-1:0] reg_raddr;
    logic [`QLA_DATA_W-1:0] reg_rdata;
    qla_pkg::adc_fb_t       adc;
    qla_pkg::dac_spi_t      dac_spi;
    logic [3:0]             amp_en;
    logic [3:0]             board_id;

    byte         vec_op[$];          // one entry per vector line
    logic [31:0] vec_addr[$];
    logic [31:0] vec_data[$];
    logic [31:0] vec_exp[$];
    logic [23:0] frames[$];          // captured dac frames, oldest first
    logic [23:0] frame_sr;
    int          frame_bits = 0;
    int          errors = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cycles = 0;
    int          cycle_limit = 0;    // 0 until vectors are loaded

    qla_ctrl_top DUT (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata),
        .adc       (adc),
        .dac_spi   (dac_spi),
        .amp_en    (amp_en),
        .board_id  (board_id)
    );

    always #4 sysclk = ~sysclk;      // 8 ns period

    // watchdog
    always @(posedge sysclk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // --------------------
    // dac monitor, mosi taken on rising sclk while csel is low
    always @(posedge dac_spi.sclk) begin
        if (!dac_spi.csel) begin
            frame_sr = {frame_sr[22:0], dac_spi.mosi};
            frame_bits++;
        end
    end

    always @(posedge dac_spi.csel) begin
        assert (frame_bits == 0 || frame_bits == `QLA_DAC_FRAME_BITS) else begin
            $display("DAC frame closed after %0d bits", frame_bits);
            errors++;
        end
        if (frame_bits == `QLA_DAC_FRAME_BITS)
            frames.push_back(frame_sr);
        frame_bits = 0;
    end

    // --------------------
    // vector file, comment lines start with #
    task load_vectors();
        int                 fd;
        int                 c;
        logic [31:0]        a, d, e;
        logic [8*160-1:0]   skip_buf;
        fd = $fopen("tb/qla_ctrl_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test vector file");
            errors++;
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                void'($fgets(skip_buf, fd));           // rest of the comment
            end else if (c >= "a" && c <= "z") begin
                if ($fscanf(fd, "%h %h %h", a, d, e) == 3) begin
                    vec_op.push_back(byte'(c));
                    vec_addr.push_back(a);
                    vec_data.push_back(d);
                    vec_exp.push_back(e);
                end
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    task drive_write(input logic [15:0] addr, input logic [31:0] data, input logic blk);
        @(posedge sysclk);
        reg_wr.waddr   <= addr;
        reg_wr.wdata   <= data;
        reg_wr.wen     <= 1'b1;
        reg_wr.blk_wen <= blk;       // held between block cycles
        @(posedge sysclk);
        reg_wr.wen     <= 1'b0;
    endtask

    task check_read(input logic [15:0] addr, input logic [31:0] exp_val);
        logic is_status;
        is_status = (addr[15:12] == `QLA_ADDR_MAIN) && (addr[7:4] == 4'd0)
                 && (addr[3:0] == `QLA_OFF_STATUS);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(posedge sysclk);           // rdata loads here
        @(negedge sysclk);
        assert (reg_rdata === exp_val) else begin
            $display("error reg_rdata at 0x%04h: got 0x%08h, expected 0x%08h",
                     addr, reg_rdata, exp_val);
            errors++;
        end
        if (is_status) begin
            // enable pins follow status bits 3:0
            assert (amp_en === exp_val[3:0]) else begin
                $display("error amp_en: got 0x%01h, expected 0x%01h", amp_en, exp_val[3:0]);
                errors++;
            end
        end
    endtask

    task send_adc(input logic [31:0] axis, input logic [31:0] data, input logic [31:0] count);
        int idx;
        idx = axis - 1;
        repeat (count) begin
            @(posedge sysclk);
            adc.cur_fb[idx] <= data[15:0];
            adc.pot_fb[idx] <= data[31:16];
            adc.cur_valid   <= 1'b1;
            @(posedge sysclk);
            adc.cur_valid   <= 1'b0;
        end
    endtask

    task wait_dac_done();
        @(posedge sysclk);
        reg_wr.blk_wen <= 1'b0;      // block ends, update may fire
        @(negedge sysclk);
        while (!DUT.dac_busy)
            @(negedge sysclk);
        while (DUT.dac_busy)
            @(negedge sysclk);
    endtask

    task check_frame_count(input logic [31:0] count);
        @(negedge sysclk);
        while (DUT.dac_busy)         // a running transfer finishes first
            @(negedge sysclk);
        assert (frames.size() == count) else begin
            $display("%0d DAC frames seen where %0d were expected", frames.size(), count);
            errors++;
        end
    endtask

    task check_frame(input logic [31:0] k, input logic [31:0] exp_val);
        logic [23:0] got;
        assert (frames.size() > 0) else begin
            $display("no DAC frame left to compare with frame %0d", k);
            errors++;
        end
        if (frames.size() > 0) begin
            got = frames.pop_front();
            assert (got === exp_val[23:0]) else begin
                $display("error dac_spi frame %0d: got 0x%06h, expected 0x%06h",
                         k, got, exp_val[23:0]);
                errors++;
            end
        end
    endtask

    task run_vector(input byte op, input logic [31:0] a, input logic [31:0] d,
                    input logic [31:0] e);
        case (op)
            "w", "b": drive_write(a[15:0], d, op == "b");
            "r":      check_read(a[15:0], e);
            "a":      send_adc(a, d, e);
            "i":      repeat (d) @(posedge sysclk);
            "u":      wait_dac_done();
            "d":      check_frame(a, e);
            "c":      check_frame_count(e);
            default: begin
                $display("unknown operation %c in the vector file", op);
                errors++;
            end
        endcase
    endtask

    // --------------------
    // main sequence
    initial begin
        int err_before;
        rst_n         = 1'b0;
        reg_wr        = '0;
        reg_raddr     = '0;
        adc.cur_fb    = {`QLA_NUM_AXES{`QLA_CUR_MID}};   // zero current
        adc.pot_fb    = '0;
        adc.cur_valid = 1'b0;
        board_id      = 4'ha;
        load_vectors();
        cycle_limit = vec_op.size() * 400;
        repeat (8) @(posedge sysclk);
        rst_n <= 1'b1;
        for (int i = 0; i < vec_op.size(); i++) begin
            err_before = errors;
            run_vector(vec_op[i], vec_addr[i], vec_data[i], vec_exp[i]);
            if (errors == err_before) begin
                pass_cnt++;
                $display("test %0d (%c): pass", i + 1, vec_op[i]);
            end else begin
                fail_cnt++;
                $display("test %0d (%c): FAIL", i + 1, vec_op[i]);
            end
        end
        repeat (4) @(posedge sysclk);
        $display("passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (errors == 0 && vec_op.size() > 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- qla_ctrl_top.f
+incdir+include
src/qla_pkg.sv
src/motor_cmd_regs.sv
src/dac_spi_ctrl.sv
src/safety_check.sv
src/board_regs.sv
src/qla_ctrl_top.sv
tb/tb_qla_ctrl_top.sv

//--- Bender.yml
package:
  name: qla_ctrl

export_include_dirs:
  - include

sources:
  - files:
      - src/qla_pkg.sv
      - src/motor_cmd_regs.sv
      - src/dac_spi_ctrl.sv
      - src/safety_check.sv
      - src/board_regs.sv
      - src/qla_ctrl_top.sv
  - target: test
    files:
      - tb/tb_qla_ctrl_top.sv

//--- tb/qla_ctrl_tests.txt
# op addr_or_axis data expect_or_count, hex; w write, b block write, r read, a adc x count
# i idle data cycles, u end block and wait for dac, c frame count, d dac frame
r 0011 0 00008000
r 0041 0 00008000
r 0000 0 0a000000
w 0011 dead1111 0
w 0001 00005555 0
w 0013 00003333 0
r 0011 0 00001111
r 0021 0 00008000
c 0 0 0
b 0011 0000a1b2 0
b 0021 00004c3d 0
b 0031 00007e00 0
b 0041 00008f01 0
u 0 0 0
c 0 0 4
d 1 0 0030a1b2
d 2 0 00314c3d
d 3 0 00327e00
d 4 0 00338f01
a 1 12348012 1
a 3 0f0f80ab 1
r 0010 0 12348012
r 0030 0 0f0f80ab
w 0021 00008100 0
w 0000 000c0202 0
r 0000 0 0a080002
a 2 abcd8400 3
a 2 abcd8200 1
i 0 3 0
r 0000 0 0a080002
a 2 abcd8400 4
i 0 3 0
r 0000 0 0a080020
r 0022 0 00008100
w 0000 00000202 0
r 0000 0 0a080002
r 0022 0 10008100
